// ==== pr_pkg.sv ====
package pr_pkg;

  //////////////////////////////
  // Widths and depths
  //////////////////////////////
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;
  localparam int MEM_WORDS   = 256;
  localparam int ADDR_W      = 8;
  localparam int TAG_W       = 8;
  localparam int LEN_W       = 8;

  // Register stages on each boundary channel
  localparam int PIPE_STAGES = 1;

  //////////////////////////////
  // Types
  //////////////////////////////
  typedef logic [DATA_W-1:0] data_t;

  // Word address, wraps modulo MEM_WORDS
  typedef logic [ADDR_W-1:0] addr_t;

  // Input descriptor, len counts words and is 1 to 255
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    addr_t            addr;
    logic [LEN_W-1:0] len;
  } desc_t;

  // Result descriptor with the modulo 2^32 word sum
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [LEN_W-1:0] len;
    data_t            sum;
  } result_t;

  // DMA write command
  typedef struct packed {
    addr_t             addr;
    data_t             data;
    logic [STRB_W-1:0] strb;
  } dma_wr_t;

endpackage

// ==== mem_rd_if.sv ====
`timescale 1ns/100ps

interface mem_rd_if import pr_pkg::*; ();

  logic  en;
  addr_t addr;
  data_t data;
  logic  data_valid;

  // Engine side issues reads
  modport master (
    output en, addr,
    input  data, data_valid
  );

  // Memory side answers one cycle after en
  modport slave (
    input  en, addr,
    output data, data_valid
  );

endinterface

// ==== pipe_reg.sv ====
`timescale 1ns/100ps

module pipe_reg #(
  parameter type T      = logic [31:0],
  parameter int  STAGES = 1
) (
  input  logic clk,
  input  logic reset,
  input  T     s_data,
  input  logic s_valid,
  output logic s_ready,
  output T     m_data,
  output logic m_valid,
  input  logic m_ready
);

  // Link i feeds stage i, link STAGES is the output
  T              link_data [STAGES+1];
  logic [STAGES:0] link_valid;
  logic [STAGES:0] link_ready;

  assign link_data[0]       = s_data;
  assign link_valid[0]      = s_valid;
  assign s_ready            = link_ready[0];
  assign m_data             = link_data[STAGES];
  assign m_valid            = link_valid[STAGES];
  assign link_ready[STAGES] = m_ready;

  for (genvar i = 0; i < STAGES; i++) begin : g_stage
    T     main_data;
    T     spare_data;
    logic main_valid;
    logic spare_valid;
    logic out_ready;

    assign out_ready         = link_ready[i+1];
    assign link_data[i+1]    = main_data;
    assign link_valid[i+1]   = main_valid;
    // Ready only while the spare slot is free
    assign link_ready[i]     = ~spare_valid;

    always_ff @(posedge clk) begin
      if (reset) begin
        main_valid  <= 1'b0;
        spare_valid <= 1'b0;
      end else if (out_ready || !main_valid) begin
        main_valid  <= spare_valid || link_valid[i];
        spare_valid <= 1'b0;
      end else if (link_valid[i] && !spare_valid) begin
        spare_valid <= 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (out_ready || !main_valid) begin
        main_data <= spare_valid ? spare_data : link_data[i];
      end else if (!spare_valid) begin
        spare_data <= link_data[i];
      end
    end
  end

  // Output payload is held while stalled
  assert property (@(posedge clk) disable iff (reset)
    m_valid && !m_ready |=> $stable(m_data));

endmodule

// ==== pkt_mem.sv ====
`timescale 1ns/100ps

module pkt_mem import pr_pkg::*; (
  input  logic    clk,
  input  logic    reset,

  input  dma_wr_t wr_cmd,
  input  logic    wr_valid,
  output logic    wr_ready,

  input  addr_t   rd_addr,
  input  logic    rd_valid,
  output logic    rd_ready,

  output data_t   resp_data,
  output logic    resp_valid,
  input  logic    resp_ready,

  mem_rd_if.slave eng
);

  data_t mem [MEM_WORDS];
  logic  wr_fire;
  logic  rd_fire;

  assign wr_fire  = wr_valid && wr_ready;
  // New command only when the held response is empty or leaving
  assign rd_ready = !resp_valid || resp_ready;
  assign rd_fire  = rd_valid && rd_ready;

  //////////////////////////////
  // Storage and read data
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr_cmd.strb[b]) begin
          mem[wr_cmd.addr][8*b +: 8] <= wr_cmd.data[8*b +: 8];
        end
      end
    end
    if (rd_fire) begin
      resp_data <= mem[rd_addr];
    end
    if (eng.en) begin
      eng.data <= mem[eng.addr];
    end
  end

  //////////////////////////////
  // Control
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ready       <= 1'b0;
      resp_valid     <= 1'b0;
      eng.data_valid <= 1'b0;
    end else begin
      wr_ready       <= 1'b1;
      eng.data_valid <= eng.en;
      if (rd_fire) begin
        resp_valid <= 1'b1;
      end else if (resp_ready) begin
        resp_valid <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    wr_valid |-> !$isunknown(wr_cmd.strb));

endmodule

// ==== desc_engine.sv ====
`timescale 1ns/100ps

module desc_engine import pr_pkg::*; (
  input  logic     clk,
  input  logic     reset,

  input  desc_t    desc,
  input  logic     desc_valid,
  output logic     desc_ready,

  output result_t  result,
  output logic     result_valid,
  input  logic     result_ready,

  mem_rd_if.master mem
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_STREAM,
    S_DONE
  } state_t;

  state_t           state;
  desc_t            cur;
  logic [LEN_W-1:0] issue_left;
  logic [LEN_W-1:0] recv_left;
  data_t            acc;
  logic             last_word;

  assign desc_ready   = (state == S_IDLE);
  assign result_valid = (state == S_DONE);
  assign result.tag   = cur.tag;
  assign result.len   = cur.len;
  assign result.sum   = acc;

  // One read per cycle until all addresses are issued
  assign mem.en    = (state == S_STREAM) && (issue_left != '0);
  assign mem.addr  = cur.addr;
  assign last_word = mem.data_valid && (recv_left == LEN_W'(1));

  //////////////////////////////
  // FSM
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (desc_valid) begin
            state <= S_STREAM;
          end
        end
        S_STREAM: begin
          if (last_word) begin
            state <= S_DONE;
          end
        end
        S_DONE: begin
          if (result_ready) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Address and counters, reads overlap with returning data
  always_ff @(posedge clk) begin
    if (desc_valid && desc_ready) begin
      cur        <= desc;
      issue_left <= desc.len;
      recv_left  <= desc.len;
      acc        <= '0;
    end else if (state == S_STREAM) begin
      if (mem.en) begin
        cur.addr   <= cur.addr + 1'b1;
        issue_left <= issue_left - 1'b1;
      end
      if (mem.data_valid) begin
        acc       <= acc + mem.data;
        recv_left <= recv_left - 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    desc_valid && desc_ready |-> desc.len != '0);

endmodule

// ==== pr_top.sv ====
`timescale 1ns/100ps

module pr_top import pr_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              core_reset,

  input  logic              dma_wr_en,
  input  addr_t             dma_wr_addr,
  input  data_t             dma_wr_data,
  input  logic [STRB_W-1:0] dma_wr_strb,
  output logic              dma_wr_ready,

  input  logic              dma_rd_en,
  input  addr_t             dma_rd_addr,
  output logic              dma_rd_ready,

  output logic              dma_rd_resp_valid,
  output data_t             dma_rd_resp_data,
  input  logic              dma_rd_resp_ready,

  input  desc_t             in_desc,
  input  logic              in_desc_valid,
  output logic              in_desc_taken,

  output result_t           out_desc,
  output logic              out_desc_valid,
  input  logic              out_desc_ready
);

  //////////////////////////////
  // Registered resets
  //////////////////////////////
  logic reset_r;
  logic core_reset_r;
  logic core_rst;

  always_ff @(posedge clk) begin
    reset_r      <= reset;
    core_reset_r <= core_reset;
  end

  // Core path also clears on core reset, memory keeps its data
  assign core_rst = reset_r || core_reset_r;

  //////////////////////////////
  // DMA channels
  //////////////////////////////
  dma_wr_t wr_cmd_in;
  dma_wr_t wr_cmd_r;
  logic    wr_valid_r;
  logic    wr_ready_r;
  addr_t   rd_addr_r;
  logic    rd_valid_r;
  logic    rd_ready_r;
  data_t   resp_data_n;
  logic    resp_valid_n;
  logic    resp_ready_n;

  assign wr_cmd_in.addr = dma_wr_addr;
  assign wr_cmd_in.data = dma_wr_data;
  assign wr_cmd_in.strb = dma_wr_strb;

  pipe_reg #(.T(dma_wr_t), .STAGES(PIPE_STAGES)) dma_wr_reg (
    .clk(clk), .reset(reset_r),
    .s_data(wr_cmd_in), .s_valid(dma_wr_en), .s_ready(dma_wr_ready),
    .m_data(wr_cmd_r), .m_valid(wr_valid_r), .m_ready(wr_ready_r)
  );

  pipe_reg #(.T(addr_t), .STAGES(PIPE_STAGES)) dma_rd_reg (
    .clk(clk), .reset(reset_r),
    .s_data(dma_rd_addr), .s_valid(dma_rd_en), .s_ready(dma_rd_ready),
    .m_data(rd_addr_r), .m_valid(rd_valid_r), .m_ready(rd_ready_r)
  );

  pipe_reg #(.T(data_t), .STAGES(PIPE_STAGES)) dma_rd_resp_reg (
    .clk(clk), .reset(reset_r),
    .s_data(resp_data_n), .s_valid(resp_valid_n), .s_ready(resp_ready_n),
    .m_data(dma_rd_resp_data), .m_valid(dma_rd_resp_valid),
    .m_ready(dma_rd_resp_ready)
  );

  //////////////////////////////
  // Descriptor channels
  //////////////////////////////
  desc_t   desc_r;
  logic    desc_valid_r;
  logic    desc_ready_r;
  result_t result_n;
  logic    result_valid_n;
  logic    result_ready_n;

  pipe_reg #(.T(desc_t), .STAGES(PIPE_STAGES)) in_desc_reg (
    .clk(clk), .reset(core_rst),
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_taken),
    .m_data(desc_r), .m_valid(desc_valid_r), .m_ready(desc_ready_r)
  );

  pipe_reg #(.T(result_t), .STAGES(PIPE_STAGES)) out_desc_reg (
    .clk(clk), .reset(core_rst),
    .s_data(result_n), .s_valid(result_valid_n), .s_ready(result_ready_n),
    .m_data(out_desc), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  //////////////////////////////
  // Memory and engine
  //////////////////////////////
  mem_rd_if eng_rd ();

  pkt_mem mem_inst (
    .clk(clk), .reset(reset_r),
    .wr_cmd(wr_cmd_r), .wr_valid(wr_valid_r), .wr_ready(wr_ready_r),
    .rd_addr(rd_addr_r), .rd_valid(rd_valid_r), .rd_ready(rd_ready_r),
    .resp_data(resp_data_n), .resp_valid(resp_valid_n), .resp_ready(resp_ready_n),
    .eng(eng_rd.slave)
  );

  desc_engine engine_inst (
    .clk(clk), .reset(core_rst),
    .desc(desc_r), .desc_valid(desc_valid_r), .desc_ready(desc_ready_r),
    .result(result_n), .result_valid(result_valid_n), .result_ready(result_ready_n),
    .mem(eng_rd.master)
  );

endmodule

// ==== tb_pr_top.sv ====
`timescale 1ns/100ps

module tb_pr_top import pr_pkg::*; ();

  localparam int N_STRB      = 24;
  localparam int N_RAND_RD   = 32;
  localparam int N_STREAM    = 12;
  localparam int N_RAND_DESC = 12;
  localparam int N_FLUSH     = 3;

  logic              clk;
  logic              reset;
  logic              core_reset;
  logic              dma_wr_en;
  addr_t             dma_wr_addr;
  data_t             dma_wr_data;
  logic [STRB_W-1:0] dma_wr_strb;
  logic              dma_wr_ready;
  logic              dma_rd_en;
  addr_t             dma_rd_addr;
  logic              dma_rd_ready;
  logic              dma_rd_resp_valid;
  data_t             dma_rd_resp_data;
  logic              dma_rd_resp_ready;
  desc_t             in_desc;
  logic              in_desc_valid;
  logic              in_desc_taken;
  result_t           out_desc;
  logic              out_desc_valid;
  logic              out_desc_ready;

  // Memory model and expected responses
  data_t       model [MEM_WORDS];
  data_t       rd_exp [$];
  result_t     res_exp [$];
  desc_t       desc_list [$];

  integer      seed = 32'h19b5;
  logic [31:0] ready_bits;
  logic        random_ready;
  logic        hold_results;
  string       test_name;
  int          budget_ns;

  pr_top UUT (.*);

  always #2 clk = ~clk;

  //////////////////////////////
  // Reference and checks
  //////////////////////////////
  function automatic data_t merge_bytes(data_t old_word, data_t new_word,
                                        logic [STRB_W-1:0] strb);
    data_t word;
    word = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  // Word sum over the packet, addresses wrap at the top of memory
  function automatic result_t compute_result(desc_t d, data_t mem_model [MEM_WORDS]);
    result_t r;
    addr_t   a;
    r.tag = d.tag;
    r.len = d.len;
    r.sum = '0;
    a     = d.addr;
    for (int i = 0; i < int'(d.len); i++) begin
      r.sum = r.sum + mem_model[a];
      a     = a + 8'd1;
    end
    return r;
  endfunction

  function automatic desc_t make_desc(logic [7:0] tag, addr_t addr, logic [7:0] len);
    desc_t d;
    d.tag  = tag;
    d.addr = addr;
    d.len  = len;
    return d;
  endfunction

  function automatic desc_t random_desc();
    logic [31:0] bits;
    desc_t       d;
    bits   = $random(seed);
    d.tag  = bits[7:0];
    d.addr = bits[15:8];
    d.len  = 8'(bits[21:16]) + 8'd1;
    return d;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_result(input string name, input result_t exp, input result_t act);
    if (act !== exp) begin
      stop_on_error($sformatf(
        "FAIL %s: expected tag %h len %0d sum %h, actual tag %h len %0d sum %h",
        name, exp.tag, exp.len, exp.sum, act.tag, act.len, act.sum));
    end
  endtask

  //////////////////////////////
  // Channel drivers
  //////////////////////////////
  task automatic write_word(input addr_t addr, input data_t data,
                            input logic [STRB_W-1:0] strb);
    dma_wr_en   = 1'b1;
    dma_wr_addr = addr;
    dma_wr_data = data;
    dma_wr_strb = strb;
    do begin
      @(negedge clk);
    end while (dma_wr_ready !== 1'b1);
    @(posedge clk);
    #0.5;
    dma_wr_en   = 1'b0;
    model[addr] = merge_bytes(model[addr], data, strb);
  endtask

  task automatic read_word(input addr_t addr);
    dma_rd_en   = 1'b1;
    dma_rd_addr = addr;
    do begin
      @(negedge clk);
    end while (dma_rd_ready !== 1'b1);
    @(posedge clk);
    #0.5;
    dma_rd_en = 1'b0;
    rd_exp.push_back(model[addr]);
  endtask

  task automatic send_desc(input desc_t d);
    in_desc       = d;
    in_desc_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (in_desc_taken !== 1'b1);
    @(posedge clk);
    #0.5;
    in_desc_valid = 1'b0;
    res_exp.push_back(compute_result(d, model));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #0.5;
  endtask

  task automatic wait_drained();
    while (rd_exp.size() != 0 || res_exp.size() != 0) begin
      @(posedge clk);
    end
    wait_cycles(1);
  endtask

  // Output side ready, random or held low while results are parked
  always @(posedge clk) begin
    #0.5;
    if (random_ready) begin
      ready_bits        = $random(seed);
      dma_rd_resp_ready = ready_bits[0];
      out_desc_ready    = ready_bits[1] && !hold_results;
    end else begin
      dma_rd_resp_ready = 1'b1;
      out_desc_ready    = !hold_results;
    end
  end

  // Transfers complete on the next rising edge
  always @(negedge clk) begin
    if (dma_rd_resp_valid === 1'b1 && dma_rd_resp_ready === 1'b1) begin
      if (rd_exp.size() == 0) begin
        stop_on_error("A read response arrived with no read outstanding");
      end else begin
        check_word(test_name, rd_exp.pop_front(), dma_rd_resp_data);
      end
    end
    if (out_desc_valid === 1'b1 && out_desc_ready === 1'b1) begin
      if (res_exp.size() == 0) begin
        stop_on_error("A result arrived with no descriptor outstanding");
      end else begin
        check_result(test_name, res_exp.pop_front(), out_desc);
      end
    end
  end

  initial begin
    wait (budget_ns != 0);
    #(budget_ns);
    stop_on_error($sformatf("Timeout after %0d ns with transfers still pending", budget_ns));
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    logic [31:0] bits;
    int          work;
    clk               = 1'b0;
    reset             = 1'b1;
    core_reset        = 1'b0;
    dma_wr_en         = 1'b0;
    dma_wr_addr       = '0;
    dma_wr_data       = '0;
    dma_wr_strb       = '0;
    dma_rd_en         = 1'b0;
    dma_rd_addr       = '0;
    dma_rd_resp_ready = 1'b1;
    in_desc           = '0;
    in_desc_valid     = 1'b0;
    out_desc_ready    = 1'b1;
    random_ready      = 1'b0;
    hold_results      = 1'b0;
    test_name         = "reset";

    // Fixed cases first, the third and fourth wrap past 255
    desc_list.push_back(make_desc(8'h11, 8'h00, 8'd1));
    desc_list.push_back(make_desc(8'h22, 8'h10, 8'd40));
    desc_list.push_back(make_desc(8'h33, 8'hf0, 8'd32));
    desc_list.push_back(make_desc(8'h44, 8'h80, 8'd255));
    repeat (N_STREAM + N_RAND_DESC + N_FLUSH + 1) begin
      desc_list.push_back(random_desc());
    end
    work = MEM_WORDS + 3 * N_STRB + N_RAND_RD + MEM_WORDS;
    foreach (desc_list[i]) begin
      work = work + 2 + int'(desc_list[i].len);
    end
    budget_ns = 20 * work + 2000;

    repeat (2) @(posedge clk);
    #0.5;
    reset = 1'b0;
    wait_cycles(4);

    test_name = "strobed write and read";
    for (int a = 0; a < MEM_WORDS; a++) begin
      write_word(addr_t'(a), $random(seed), 4'hf);
    end
    for (int i = 0; i < N_STRB; i++) begin
      bits = $random(seed);
      write_word(bits[7:0], $random(seed), bits[11:8]);
      read_word(bits[7:0]);
      read_word(bits[23:16]);
    end
    wait_drained();

    test_name = "single descriptor";
    repeat (4) begin
      send_desc(desc_list.pop_front());
      wait_drained();
    end

    test_name = "descriptor stream";
    repeat (N_STREAM) begin
      send_desc(desc_list.pop_front());
    end
    wait_drained();

    test_name    = "random back-pressure";
    random_ready = 1'b1;
    fork
      for (int i = 0; i < N_RAND_RD; i++) begin
        read_word(addr_t'(i * 37));
      end
      repeat (N_RAND_DESC) begin
        send_desc(desc_list.pop_front());
      end
    join
    wait_drained();
    random_ready = 1'b0;

    // Park results, then clear the core with descriptors in flight
    test_name    = "core reset";
    hold_results = 1'b1;
    wait_cycles(2);
    repeat (N_FLUSH) begin
      send_desc(desc_list.pop_front());
    end
    do begin
      @(negedge clk);
    end while (out_desc_valid !== 1'b1);
    wait_cycles(1);
    core_reset = 1'b1;
    wait_cycles(2);
    core_reset = 1'b0;
    wait_cycles(3);
    if (out_desc_valid !== 1'b0) begin
      stop_on_error("out_desc_valid is still high after the core reset");
    end
    res_exp.delete();
    hold_results = 1'b0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      read_word(addr_t'(a));
    end
    send_desc(desc_list.pop_front());
    wait_drained();

    if (rd_exp.size() == 0 && res_exp.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      stop_on_error("Expected responses were left over at the end of the run");
    end
  end

endmodule

// ==== all.f ====
pr_pkg.sv
mem_rd_if.sv
pipe_reg.sv
pkt_mem.sv
desc_engine.sv
pr_top.sv
tb_pr_top.sv

// ==== Makefile ====
# Verilator simulation of the packet boundary testbench

VERILATOR ?= verilator
TOP       ?= tb_pr_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_TEXT ?= Test failures found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Simulation FAILED, see $(LOG)"; \
	  exit 1; \
	fi
	@echo "Simulation passed, see $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
